// File: stream_input.dat
# Columns: kind value. C = config address (hex), W = stream word (hex),
# I = idle gap in clock cycles (hex)
C 0100
W a1000001
W a1000002
W a1000003
W a1000004
W a1000005
W a1000006
W a1000007
W a1000008
W a1000009
W a100000a
W a100000b
W a100000c
W a100000d
W a100000e
W a100000f
W a1000010
W a1000011
W a1000012
I 20
C 0ff4
W b2000001
W b2000002
W b2000003
W b2000004
W b2000005
W b2000006
W b2000007
W b2000008
W b2000009
W b200000a
I 28
C 2000
W c3000001
W c3000002
W c3000003
W c3000004
I 2
W c3000005
W c3000006
W c3000007
W c3000008
W c3000009
I 30
C 3ff0
W d4000001
W d4000002
W d4000003
W d4000004

// File: sim.f
axi_pkg.sv
s2m_pkg.sv
fifo_ram_2p.sv
fifo_sync.sv
axis2axi_in.sv
axis2axi_top.sv
tb_axi_mem.sv
tb_axis2axi.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f sim.f --top-module tb_axis2axi
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_axis2axi)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "=== PASS ==="; then
   exit 0
fi
exit 1

// File: tb_axis2axi.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axis2axi;

   import axi_pkg::*;

   localparam int TIMEOUT = 1000;

   logic                  clk_i;
   logic                  rst_i;
   logic [AXI_ADDR_W-1:0] cfg_addr_i;
   logic                  cfg_valid_i;
   logic                  cfg_ready_o;
   logic [AXI_DATA_W-1:0] s_data_i;
   logic                  s_valid_i;
   logic                  s_ready_o;
   axi_aw_t               m_aw_o;
   logic                  m_awvalid_o;
   logic                  m_awready_i;
   axi_w_t                m_w_o;
   logic                  m_wvalid_o;
   logic                  m_wready_i;
   axi_b_t                m_b_i;
   logic                  m_bvalid_i;
   logic                  m_bready_o;
   int                    slave_beats;
   int                    slave_errors;

   logic [31:0] exp_mem [int];
   logic [15:0] exp_addr;
   logic [15:0] burst_addr;
   int          errors;
   int          timeouts;
   int          total_words;
   int          acc;
   int          res;
   int          prev_lvl;
   logic        prev_svalid;
   logic        aw_prev;
   logic        saw_full;

   axis2axi_top #(
      .BURST_W(3)
   ) dut_i (
      .clk_i(clk_i), .rst_i(rst_i),
      .cfg_addr_i(cfg_addr_i), .cfg_valid_i(cfg_valid_i), .cfg_ready_o(cfg_ready_o),
      .s_data_i(s_data_i), .s_valid_i(s_valid_i), .s_ready_o(s_ready_o),
      .m_aw_o(m_aw_o), .m_awvalid_o(m_awvalid_o), .m_awready_i(m_awready_i),
      .m_w_o(m_w_o), .m_wvalid_o(m_wvalid_o), .m_wready_i(m_wready_i),
      .m_b_i(m_b_i), .m_bvalid_i(m_bvalid_i), .m_bready_o(m_bready_o)
   );

   tb_axi_mem #(
      .SEED(32'h6b24891e)
   ) mem_i (
      .clk_i(clk_i), .rst_i(rst_i),
      .aw_i(m_aw_o), .awvalid_i(m_awvalid_o), .awready_o(m_awready_i),
      .w_i(m_w_o), .wvalid_i(m_wvalid_o), .wready_o(m_wready_i),
      .b_o(m_b_i), .bvalid_o(m_bvalid_i),
      .beats_o(slave_beats), .errors_o(slave_errors)
   );

   initial clk_i = 0;
   always #4 clk_i = ~clk_i;

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // Handshake completes on the next rising edge
   task automatic send_cfg(input logic [15:0] addr);
      int n;
      n = 0;
      cfg_addr_i = addr;
      cfg_valid_i = 1;
      while (timeouts == 0) begin
         @(negedge clk_i);
         if (cfg_ready_o) break;
         n++;
         if (n > TIMEOUT) begin
            $display("Timeout: config address %h was never accepted", addr);
            timeouts++;
         end
      end
      @(posedge clk_i);
      #1;
      cfg_valid_i = 0;
   endtask

   task automatic send_word(input logic [31:0] data);
      int n;
      n = 0;
      s_data_i = data;
      s_valid_i = 1;
      while (timeouts == 0) begin
         @(negedge clk_i);
         if (s_ready_o) break;
         n++;
         if (n > TIMEOUT) begin
            $display("Timeout: stream word %h was never accepted", data);
            timeouts++;
         end
      end
      @(posedge clk_i);
      #1;
      s_valid_i = 0;
   endtask

   // Expected burst sizes follow from the words handed over so far
   always @(negedge clk_i) begin
      int lvl;
      int exp_len;
      int room;
      if (!rst_i) begin
         lvl = acc - res;
         if (cfg_valid_i && cfg_ready_o) begin
            burst_addr = cfg_addr_i;
         end
         if (m_awvalid_o && !aw_prev) begin
            exp_len = (prev_lvl >= 8) ? 8 : prev_lvl;
            if (prev_lvl < 8) begin
               check_eq("s_valid_i at short burst", 32'(prev_svalid), 32'h0);
            end
            room = (4096 - int'(burst_addr[11:0])) / 4;
            if (exp_len > room) begin
               exp_len = room;
            end
            check_eq("m_aw_o.addr", 32'(m_aw_o.addr), 32'(burst_addr));
            check_eq("m_aw_o.len", 32'(m_aw_o.len), 32'(exp_len - 1));
            res += exp_len;
            burst_addr = burst_addr + 16'(4 * exp_len);
         end
         // Write responses are always taken
         if (m_bvalid_i) begin
            check_eq("m_bready_o", 32'(m_bready_o), 32'h1);
         end
         aw_prev = m_awvalid_o;
         prev_lvl = lvl;
         prev_svalid = s_valid_i;
         if (s_valid_i && s_ready_o) begin
            acc++;
         end
         if (!s_ready_o) begin
            saw_full = 1;
         end
      end
   end

   initial begin
      int fd;
      int n;
      string line;
      string kind;
      logic [31:0] val;
      rst_i = 1;
      cfg_addr_i = '0;
      cfg_valid_i = 0;
      s_data_i = '0;
      s_valid_i = 0;
      errors = 0;
      timeouts = 0;
      total_words = 0;
      acc = 0;
      res = 0;
      prev_lvl = 0;
      prev_svalid = 0;
      aw_prev = 0;
      saw_full = 0;
      exp_addr = '0;
      burst_addr = '0;
      fd = $fopen("stream_input.dat", "r");
      if (fd == 0) begin
         $display("Could not open stream_input.dat");
         errors++;
      end
      repeat (10) @(posedge clk_i);
      #1;
      rst_i = 0;
      @(negedge clk_i);
      check_eq("m_awvalid_o", 32'(m_awvalid_o), 32'h0);
      check_eq("m_wvalid_o", 32'(m_wvalid_o), 32'h0);
      check_eq("cfg_ready_o", 32'(cfg_ready_o), 32'h1);
      check_eq("s_ready_o", 32'(s_ready_o), 32'h1);
      @(posedge clk_i);
      #1;
      while (fd != 0 && timeouts == 0 && !$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() == 0 || line.getc(0) == 8'h23) continue;
         n = $sscanf(line, "%s %h", kind, val);
         if (n != 2) continue;
         if (kind == "C") begin
            exp_addr = val[15:0];
            send_cfg(val[15:0]);
         end else if (kind == "W") begin
            exp_mem[int'(exp_addr)] = val;
            exp_addr = exp_addr + 16'd4;
            total_words++;
            send_word(val);
         end else if (kind == "I") begin
            repeat (int'(val)) @(posedge clk_i);
            #1;
         end
      end
      if (fd != 0) begin
         $fclose(fd);
      end
      // Drain until every word has been written back
      n = 0;
      while (timeouts == 0) begin
         @(negedge clk_i);
         if (slave_beats == total_words && cfg_ready_o) break;
         n++;
         if (n > TIMEOUT) begin
            $display("Timeout: memory writes did not complete");
            timeouts++;
         end
      end
      foreach (exp_mem[a]) begin
         check_eq($sformatf("mem[%h]", a[15:0]), mem_i.peek(a), exp_mem[a]);
      end
      check_eq("memory word count", 32'(mem_i.word_count()), 32'(exp_mem.num()));
      check_eq("s_ready_o low seen", 32'(saw_full), 32'h1);
      $display("Errors: checks=%0d model=%0d timeouts=%0d", errors, slave_errors, timeouts);
      if (errors == 0 && slave_errors == 0 && timeouts == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb_axi_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem #(
   parameter logic [31:0] SEED = 32'h6b24891e
) (
   input  wire logic             clk_i,
   input  wire logic             rst_i,
   input  wire axi_pkg::axi_aw_t aw_i,
   input  wire logic             awvalid_i,
   output logic                  awready_o,
   input  wire axi_pkg::axi_w_t  w_i,
   input  wire logic             wvalid_i,
   output logic                  wready_o,
   output axi_pkg::axi_b_t       b_o,
   output logic                  bvalid_o,
   output int                    beats_o,
   output int                    errors_o
);

   import axi_pkg::*;

   logic [31:0] mem [int];
   logic [31:0] rnd;
   axi_aw_t     aw_held;
   axi_w_t      w_held;
   logic        aw_stall;
   logic        w_stall;
   logic        burst_open;
   logic        b_due;
   logic        forced_done;
   logic [15:0] burst_addr;
   logic [15:0] wr_addr;
   int          burst_len;
   int          beat;
   int          burst_idx;
   int          w_stall_cnt;
   int          aw_stall_cnt;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] peek(input int addr);
      if (mem.exists(addr)) begin
         return mem[addr];
      end
      return 'x;
   endfunction

   function automatic int word_count();
      return mem.num();
   endfunction

   // Ready and response outputs start low
   initial begin
      awready_o = 0;
      wready_o = 0;
      bvalid_o = 0;
      b_o = '0;
   end

   always @(posedge clk_i) begin
      if (rst_i) begin
         rnd = SEED;
         aw_stall = 0;
         w_stall = 0;
         burst_open = 0;
         b_due = 0;
         forced_done = 0;
         burst_idx = 0;
         w_stall_cnt = 0;
         aw_stall_cnt = 0;
         beats_o = 0;
         errors_o = 0;
         #1;
         awready_o = 0;
         wready_o = 0;
         bvalid_o = 0;
         b_o = '0;
      end else begin
         // Payloads must hold while the previous cycle stalled
         if (aw_stall && awvalid_i && aw_i !== aw_held) begin
            $display("Error at %0t: m_aw_o changed under stall, got %h expected %h",
                     $time, aw_i, aw_held);
            errors_o++;
         end
         if (w_stall && wvalid_i && w_i !== w_held) begin
            $display("Error at %0t: m_w_o changed under stall, got %h expected %h",
                     $time, w_i, w_held);
            errors_o++;
         end
         if (awvalid_i && awready_o) begin
            if (burst_open) begin
               $display("Error at %0t: second burst started before the first ended", $time);
               errors_o++;
            end
            burst_open = 1;
            burst_addr = aw_i.addr;
            burst_len = int'(aw_i.len) + 1;
            beat = 0;
            // Only 4-byte INCR bursts
            if (aw_i.size !== 3'd2) begin
               $display("Error at %0t: m_aw_o.size got %0d expected %0d",
                        $time, aw_i.size, 2);
               errors_o++;
            end
            if (aw_i.burst !== 2'b01) begin
               $display("Error at %0t: m_aw_o.burst got %b expected %b",
                        $time, aw_i.burst, 2'b01);
               errors_o++;
            end
            if (burst_len > 8) begin
               $display("Error at %0t: m_aw_o.len got %0d expected at most 7", $time, aw_i.len);
               errors_o++;
            end
            if (int'(burst_addr[11:0]) + 4 * burst_len > 4096) begin
               $display("Error at %0t: burst at %h of %0d beats crosses 4 KiB",
                        $time, burst_addr, burst_len);
               errors_o++;
            end
            if (burst_addr == 16'h0ff4 && burst_len != 3) begin
               $display("Error at %0t: m_aw_o.len got %0d expected %0d",
                        $time, aw_i.len, 2);
               errors_o++;
            end
         end
         if (wvalid_i && wready_o) begin
            if (!burst_open) begin
               $display("Error at %0t: write beat without an open burst", $time);
               errors_o++;
            end
            wr_addr = burst_addr + 16'(4 * beat);
            mem[int'(wr_addr)] = w_i.data;
            if (w_i.strb !== 4'hf) begin
               $display("Error at %0t: m_w_o.strb got %h expected %h",
                        $time, w_i.strb, 4'hf);
               errors_o++;
            end
            if (w_i.last !== (beat == burst_len - 1)) begin
               $display("Error at %0t: m_w_o.last got %0b expected %0b",
                        $time, w_i.last, beat == burst_len - 1);
               errors_o++;
            end
            beat++;
            beats_o++;
            if (w_i.last) begin
               burst_open = 0;
               b_due = 1;
               burst_idx++;
            end
         end
         aw_stall = awvalid_i && !awready_o;
         w_stall = wvalid_i && !wready_o;
         aw_held = aw_i;
         w_held = w_i;
         // Hold the first burst long enough to fill the FIFO
         if (!forced_done && burst_open && burst_idx == 0) begin
            w_stall_cnt = 30;
            forced_done = 1;
         end
         rnd = xorshift32(rnd);
         if (w_stall_cnt == 0 && rnd[7:4] == 4'h0) begin
            w_stall_cnt = 20;
         end
         if (aw_stall_cnt == 0 && rnd[11:9] == 3'h0) begin
            aw_stall_cnt = 6;
         end
         #1;
         awready_o = (aw_stall_cnt == 0) && (rnd[1:0] != 2'b00);
         wready_o = (w_stall_cnt == 0) && (rnd[3:2] != 2'b00);
         if (w_stall_cnt > 0) begin
            w_stall_cnt--;
         end
         if (aw_stall_cnt > 0) begin
            aw_stall_cnt--;
         end
         bvalid_o = b_due;
         b_o = '0;
         b_due = 0;
      end
   end

endmodule

`default_nettype wire

// File: axis2axi_top.sv
`timescale 1ns/1ps
`default_nettype none

module axis2axi_top #(
   parameter int BURST_W = 3
) (
   input  wire logic                           clk_i,
   input  wire logic                           rst_i,

   input  wire logic [axi_pkg::AXI_ADDR_W-1:0] cfg_addr_i,
   input  wire logic                           cfg_valid_i,
   output logic                                cfg_ready_o,

   input  wire logic [axi_pkg::AXI_DATA_W-1:0] s_data_i,
   input  wire logic                           s_valid_i,
   output logic                                s_ready_o,

   output axi_pkg::axi_aw_t                    m_aw_o,
   output logic                                m_awvalid_o,
   input  wire logic                           m_awready_i,
   output axi_pkg::axi_w_t                     m_w_o,
   output logic                                m_wvalid_o,
   input  wire logic                           m_wready_i,
   input  wire axi_pkg::axi_b_t                m_b_i,
   input  wire logic                           m_bvalid_i,
   output logic                                m_bready_o
);

   import axi_pkg::*;

   // FIFO holds two full bursts
   localparam int BUF_ADDR_W = BURST_W + 1;

   logic                  mem_w_en;
   logic [BUF_ADDR_W-1:0] mem_w_addr;
   logic [AXI_DATA_W-1:0] mem_w_data;
   logic                  mem_r_en;
   logic [BUF_ADDR_W-1:0] mem_r_addr;
   logic [AXI_DATA_W-1:0] mem_r_data;

   axis2axi_in #(
      .BURST_W(BURST_W)
   ) writer_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .cfg_addr_i  (cfg_addr_i),
      .cfg_valid_i (cfg_valid_i),
      .cfg_ready_o (cfg_ready_o),
      .s_data_i    (s_data_i),
      .s_valid_i   (s_valid_i),
      .s_ready_o   (s_ready_o),
      .m_aw_o      (m_aw_o),
      .m_awvalid_o (m_awvalid_o),
      .m_awready_i (m_awready_i),
      .m_w_o       (m_w_o),
      .m_wvalid_o  (m_wvalid_o),
      .m_wready_i  (m_wready_i),
      .m_b_i       (m_b_i),
      .m_bvalid_i  (m_bvalid_i),
      .m_bready_o  (m_bready_o),
      .mem_w_en_o  (mem_w_en),
      .mem_w_addr_o(mem_w_addr),
      .mem_w_data_o(mem_w_data),
      .mem_r_en_o  (mem_r_en),
      .mem_r_addr_o(mem_r_addr),
      .mem_r_data_i(mem_r_data)
   );

   fifo_ram_2p #(
      .ADDR_W(BUF_ADDR_W),
      .DATA_W(AXI_DATA_W)
   ) ram_i (
      .clk_i   (clk_i),
      .w_en_i  (mem_w_en),
      .w_addr_i(mem_w_addr),
      .w_data_i(mem_w_data),
      .r_en_i  (mem_r_en),
      .r_addr_i(mem_r_addr),
      .r_data_o(mem_r_data)
   );

endmodule

`default_nettype wire

// File: axis2axi_in.sv
`timescale 1ns/1ps
`default_nettype none

module axis2axi_in #(
   parameter int BURST_W = 3
) (
   input  wire logic                           clk_i,
   input  wire logic                           rst_i,

   // Start address of the next block
   input  wire logic [axi_pkg::AXI_ADDR_W-1:0] cfg_addr_i,
   input  wire logic                           cfg_valid_i,
   output logic                                cfg_ready_o,

   // Stream input
   input  wire logic [axi_pkg::AXI_DATA_W-1:0] s_data_i,
   input  wire logic                           s_valid_i,
   output logic                                s_ready_o,

   // AXI4 write master
   output axi_pkg::axi_aw_t                    m_aw_o,
   output logic                                m_awvalid_o,
   input  wire logic                           m_awready_i,
   output axi_pkg::axi_w_t                     m_w_o,
   output logic                                m_wvalid_o,
   input  wire logic                           m_wready_i,
   input  wire axi_pkg::axi_b_t                m_b_i,
   input  wire logic                           m_bvalid_i,
   output logic                                m_bready_o,

   // FIFO storage
   output logic                                mem_w_en_o,
   output logic      [BURST_W:0]               mem_w_addr_o,
   output logic      [axi_pkg::AXI_DATA_W-1:0] mem_w_data_o,
   output logic                                mem_r_en_o,
   output logic      [BURST_W:0]               mem_r_addr_o,
   input  wire logic [axi_pkg::AXI_DATA_W-1:0] mem_r_data_i
);

   import axi_pkg::*;
   import s2m_pkg::*;

   localparam int BURST_SIZE = 2 ** BURST_W;
   localparam int BUF_W      = BURST_W + 1;
   localparam int BOUND_W    = $clog2(BOUNDARY_BYTES);
   localparam int BEAT_SHIFT = $clog2(BYTES_PER_BEAT);

   writer_state_t          state_q;
   writer_state_t          state_d;
   logic [AXI_ADDR_W-1:0]  addr_q;
   logic [BURST_W:0]       awlen_q;
   logic [BURST_W:0]       beat_cnt_q;

   logic [BUF_W:0]         fifo_level;
   logic [AXI_DATA_W-1:0]  fifo_rd_data;
   logic                   fifo_empty;
   logic                   fifo_full;
   logic                   fifo_wr_en;
   logic                   fifo_rd_en;

   logic                   full_burst_ok;
   logic                   short_burst_ok;
   logic                   start_burst;
   logic                   cfg_hs;
   logic                   w_hs;
   logic                   last_beat;
   logic [BURST_W:0]       size_raw;
   logic [BURST_W:0]       burst_size;
   logic [BOUND_W:0]       bytes_to_bound;
   logic [BOUND_W:0]       beats_to_bound;
   logic [BOUND_W:0]       burst_end;

   assign s_ready_o   = !fifo_full;
   assign cfg_ready_o = fifo_empty && (state_q == WAIT_DATA);
   assign m_bready_o  = 1'b1;

   assign fifo_wr_en = s_valid_i && !fifo_full;
   assign cfg_hs     = cfg_valid_i && cfg_ready_o;
   assign w_hs       = m_wvalid_o && m_wready_i;
   assign last_beat  = (beat_cnt_q == awlen_q);

   // Full burst as soon as possible, short burst only when the stream pauses
   assign full_burst_ok  = (fifo_level >= (BUF_W + 1)'(BURST_SIZE));
   assign short_burst_ok = (fifo_level != '0) && !full_burst_ok && !s_valid_i;
   assign start_burst    = (state_q == WAIT_DATA) && (full_burst_ok || short_burst_ok);

   assign size_raw = full_burst_ok ? (BURST_W + 1)'(BURST_SIZE) : fifo_level[BURST_W:0];

   // Beats left before the next 4 KiB boundary
   assign bytes_to_bound = (BOUND_W + 1)'(BOUNDARY_BYTES) - {1'b0, addr_q[BOUND_W-1:0]};
   assign beats_to_bound = bytes_to_bound >> BEAT_SHIFT;
   assign burst_size     = ((BOUND_W + 1)'(size_raw) > beats_to_bound) ?
                           beats_to_bound[BURST_W:0] : size_raw;

   // First word is fetched at burst start, then one per accepted beat
   assign fifo_rd_en = start_burst || ((state_q == TRANSFER) && w_hs && !last_beat);

   assign m_awvalid_o = (state_q == START_TRANSFER);
   assign m_wvalid_o  = (state_q == TRANSFER);

   always_comb begin
      m_aw_o.addr  = addr_q;
      m_aw_o.len   = AXI_LEN_W'(awlen_q);
      m_aw_o.size  = AXI_SIZE_4B;
      m_aw_o.burst = AXI_BURST_INCR;
      m_w_o.data   = fifo_rd_data;
      m_w_o.strb   = '1;
      m_w_o.last   = last_beat;
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         WAIT_DATA: begin
            if (start_burst) begin
               state_d = START_TRANSFER;
            end
         end
         START_TRANSFER: begin
            if (m_awready_i) begin
               state_d = TRANSFER;
            end
         end
         TRANSFER: begin
            if (w_hs && last_beat) begin
               state_d = WAIT_BRESP;
            end
         end
         WAIT_BRESP: begin
            if (m_bvalid_i) begin
               state_d = WAIT_DATA;
            end
         end
         default: state_d = WAIT_DATA;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q    <= WAIT_DATA;
         addr_q     <= '0;
         awlen_q    <= '0;
         beat_cnt_q <= '0;
      end else begin
         state_q <= state_d;
         if (cfg_hs) begin
            addr_q <= cfg_addr_i;
         end else if ((state_q == WAIT_BRESP) && m_bvalid_i) begin
            addr_q <= addr_q + (AXI_ADDR_W'(awlen_q + 1'b1) << BEAT_SHIFT);
         end
         if (start_burst) begin
            awlen_q    <= burst_size - 1'b1;
            beat_cnt_q <= '0;
         end else if ((state_q == TRANSFER) && w_hs) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
         end
      end
   end

   fifo_sync #(
      .ADDR_W(BUF_W)
   ) fifo_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .w_en_i      (fifo_wr_en),
      .w_data_i    (s_data_i),
      .w_full_o    (fifo_full),
      .r_en_i      (fifo_rd_en),
      .r_data_o    (fifo_rd_data),
      .r_empty_o   (fifo_empty),
      .level_o     (fifo_level),
      .mem_w_en_o  (mem_w_en_o),
      .mem_w_addr_o(mem_w_addr_o),
      .mem_w_data_o(mem_w_data_o),
      .mem_r_en_o  (mem_r_en_o),
      .mem_r_addr_o(mem_r_addr_o),
      .mem_r_data_i(mem_r_data_i)
   );

   // End offset of the current burst within its 4 KiB page
   assign burst_end = {1'b0, addr_q[BOUND_W-1:0]} +
                      ((BOUND_W + 1)'(awlen_q + 1'b1) << BEAT_SHIFT);

   a_aw_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      m_awvalid_o && !m_awready_i |=> m_awvalid_o && $stable(m_aw_o))
      else $error("axis2axi_in: AW payload changed under stall");

   a_no_4k_cross: assert property (@(posedge clk_i) disable iff (rst_i)
      m_awvalid_o |-> burst_end <= (BOUND_W + 1)'(BOUNDARY_BYTES))
      else $error("axis2axi_in: burst crosses a 4 KiB boundary");

   // Sizing at burst start must cover every later beat read
   a_rd_not_empty: assert property (@(posedge clk_i) disable iff (rst_i)
      fifo_rd_en |-> !fifo_empty)
      else $error("axis2axi_in: beat read from an empty FIFO");

   a_bresp_known: assert property (@(posedge clk_i) disable iff (rst_i)
      m_bvalid_i && (state_q == WAIT_BRESP) |-> !$isunknown(m_b_i))
      else $error("axis2axi_in: unknown write response");

endmodule

`default_nettype wire

// File: fifo_sync.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_sync #(
   parameter int ADDR_W = 4
) (
   input  wire logic                           clk_i,
   input  wire logic                           rst_i,

   // Write side
   input  wire logic                           w_en_i,
   input  wire logic [axi_pkg::AXI_DATA_W-1:0] w_data_i,
   output logic                                w_full_o,

   // Read side, data follows r_en_i by one cycle
   input  wire logic                           r_en_i,
   output logic      [axi_pkg::AXI_DATA_W-1:0] r_data_o,
   output logic                                r_empty_o,

   output logic      [ADDR_W:0]                level_o,

   // External RAM
   output logic                                mem_w_en_o,
   output logic      [ADDR_W-1:0]              mem_w_addr_o,
   output logic      [axi_pkg::AXI_DATA_W-1:0] mem_w_data_o,
   output logic                                mem_r_en_o,
   output logic      [ADDR_W-1:0]              mem_r_addr_o,
   input  wire logic [axi_pkg::AXI_DATA_W-1:0] mem_r_data_i
);

   // Pointers carry one extra wrap bit
   logic [ADDR_W:0] w_ptr_q;
   logic [ADDR_W:0] r_ptr_q;
   logic [ADDR_W:0] level_q;
   logic            wr_ok;
   logic            rd_ok;

   // Same slot, opposite wrap means full
   assign w_full_o  = (w_ptr_q[ADDR_W] != r_ptr_q[ADDR_W]) &&
                      (w_ptr_q[ADDR_W-1:0] == r_ptr_q[ADDR_W-1:0]);
   assign r_empty_o = (w_ptr_q == r_ptr_q);

   // Requests on a full or empty FIFO are dropped
   assign wr_ok = w_en_i && !w_full_o;
   assign rd_ok = r_en_i && !r_empty_o;

   assign mem_w_en_o   = wr_ok;
   assign mem_w_addr_o = w_ptr_q[ADDR_W-1:0];
   assign mem_w_data_o = w_data_i;
   assign mem_r_en_o   = rd_ok;
   assign mem_r_addr_o = r_ptr_q[ADDR_W-1:0];
   assign r_data_o     = mem_r_data_i;

   assign level_o = level_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         w_ptr_q <= '0;
         r_ptr_q <= '0;
         level_q <= '0;
      end else begin
         if (wr_ok) begin
            w_ptr_q <= w_ptr_q + 1'b1;
         end
         if (rd_ok) begin
            r_ptr_q <= r_ptr_q + 1'b1;
         end
         // Simultaneous read and write keeps the level
         if (wr_ok && !rd_ok) begin
            level_q <= level_q + 1'b1;
         end else if (rd_ok && !wr_ok) begin
            level_q <= level_q - 1'b1;
         end
      end
   end

   // Level counter agrees with the pointer distance
   a_level_ptrs: assert property (@(posedge clk_i) disable iff (rst_i)
      level_q == w_ptr_q - r_ptr_q)
      else $error("fifo_sync: level does not match the pointers");

endmodule

`default_nettype wire

// File: fifo_ram_2p.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_ram_2p #(
   parameter int ADDR_W = 4,
   parameter int DATA_W = 32
) (
   input  wire logic              clk_i,

   // Write port
   input  wire logic              w_en_i,
   input  wire logic [ADDR_W-1:0] w_addr_i,
   input  wire logic [DATA_W-1:0] w_data_i,

   // Read port
   input  wire logic              r_en_i,
   input  wire logic [ADDR_W-1:0] r_addr_i,
   output logic      [DATA_W-1:0] r_data_o
);

   localparam int DEPTH = 2 ** ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];

   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // Read data holds between reads
   always_ff @(posedge clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

`default_nettype wire

// File: s2m_pkg.sv
`default_nettype none

package s2m_pkg;

   // Burst writer FSM states
   typedef enum logic [1:0] {
      WAIT_DATA      = 2'h0,
      START_TRANSFER = 2'h1,
      TRANSFER       = 2'h2,
      WAIT_BRESP     = 2'h3
   } writer_state_t;

   // Bursts must not cross this address boundary
   localparam int BOUNDARY_BYTES = 4096;

   // Fixed beat size in bytes
   localparam int BYTES_PER_BEAT = 4;

endpackage

`default_nettype wire

// File: axi_pkg.sv
`default_nettype none

package axi_pkg;

   // Bus widths
   localparam int AXI_ADDR_W  = 16;
   localparam int AXI_DATA_W  = 32;
   localparam int AXI_STRB_W  = AXI_DATA_W / 8;
   localparam int AXI_LEN_W   = 8;
   localparam int AXI_SIZE_W  = 3;
   localparam int AXI_BURST_W = 2;
   localparam int AXI_RESP_W  = 2;

   // Only full 4-byte beats
   localparam logic [AXI_SIZE_W-1:0] AXI_SIZE_4B = 3'd2;

   // INCR bursts only
   localparam logic [AXI_BURST_W-1:0] AXI_BURST_INCR = 2'b01;

   // Write address channel payload
   typedef struct packed {
      logic [AXI_ADDR_W-1:0]  addr;
      logic [AXI_LEN_W-1:0]   len;
      logic [AXI_SIZE_W-1:0]  size;
      logic [AXI_BURST_W-1:0] burst;
   } axi_aw_t;

   // Write data channel payload
   typedef struct packed {
      logic [AXI_DATA_W-1:0] data;
      logic [AXI_STRB_W-1:0] strb;
      logic                  last;
   } axi_w_t;

   // Write response channel payload
   typedef struct packed {
      logic [AXI_RESP_W-1:0] resp;
   } axi_b_t;

endpackage

`default_nettype wire
